/* source/isa_pkg.sv */
package isa_pkg;

   // Datapath and register file geometry
   localparam int word_w     = 32;
   localparam int reg_addr_w = 5;
   localparam int num_regs   = 32;

   // Instruction field widths
   localparam int type_w  = 5;
   localparam int alu_op_w = 5;
   localparam int imm_w   = 22;
   localparam int shamt_w = 5;

   // Instruction types; anything else behaves as a no-op
   localparam logic [type_w-1:0] itype_nop      = 5'd0;
   localparam logic [type_w-1:0] itype_load_imm = 5'd1;
   localparam logic [type_w-1:0] itype_alu      = 5'd2;
   localparam logic [type_w-1:0] itype_jump     = 5'd3;

   // ALU operations; undefined codes give zero
   localparam logic [alu_op_w-1:0] alu_add = 5'd0;
   localparam logic [alu_op_w-1:0] alu_sub = 5'd1;
   localparam logic [alu_op_w-1:0] alu_and = 5'd2;
   localparam logic [alu_op_w-1:0] alu_or  = 5'd3;
   localparam logic [alu_op_w-1:0] alu_xor = 5'd4;
   localparam logic [alu_op_w-1:0] alu_shl = 5'd5;
   localparam logic [alu_op_w-1:0] alu_shr = 5'd6;

   // One instruction word seen in its two encodings.
   // Jumps use the register format with rs0 as condition and rs1 as target
   typedef union packed {
      struct packed {
         logic [type_w-1:0]     itype;
         logic [reg_addr_w-1:0] rd;
         logic [imm_w-1:0]      imm;
      } imm_fmt;
      struct packed {
         logic [type_w-1:0]     itype;
         logic [reg_addr_w-1:0] rd;
         logic [reg_addr_w-1:0] rs0;
         logic [reg_addr_w-1:0] rs1;
         logic [alu_op_w-1:0]   op;
         logic [6:0]            unused;
      } reg_fmt;
   } instr_t;

endpackage

/* source/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder
   import isa_pkg::*;
(
   input  logic [word_w-1:0]     instr,
   output logic [type_w-1:0]     itype,
   output logic [reg_addr_w-1:0] rd,
   output logic [reg_addr_w-1:0] rs0,
   output logic [reg_addr_w-1:0] rs1,
   output logic [alu_op_w-1:0]   alu_op,
   output logic [word_w-1:0]     imm,
   output logic                  writes,
   output logic [reg_addr_w-1:0] write_reg
);

   instr_t word;

   assign word = instr;

   always_comb begin
      // Fields stay zero unless the type uses them, so unused source
      // registers never match a write in the forwarding compare
      itype  = itype_nop;
      rd     = '0;
      rs0    = '0;
      rs1    = '0;
      alu_op = '0;
      imm    = '0;
      case (word.imm_fmt.itype)
         itype_load_imm: begin
            itype = itype_load_imm;
            rd    = word.imm_fmt.rd;
            imm   = word_w'(word.imm_fmt.imm);
         end
         itype_alu: begin
            itype  = itype_alu;
            rd     = word.reg_fmt.rd;
            rs0    = word.reg_fmt.rs0;
            rs1    = word.reg_fmt.rs1;
            alu_op = word.reg_fmt.op;
         end
         itype_jump: begin
            itype = itype_jump;
            rs0   = word.reg_fmt.rs0;
            rs1   = word.reg_fmt.rs1;
         end
         default: begin
            itype = itype_nop;
         end
      endcase
   end

   // Register 0 is hardwired so a write to it is dropped here
   assign writes    = ((itype == itype_load_imm) || (itype == itype_alu)) && (rd != '0);
   assign write_reg = rd;

endmodule

/* source/register_file.sv */
`timescale 1ns/1ns

module register_file
   import isa_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [reg_addr_w-1:0] read_address_0,
   input  logic [reg_addr_w-1:0] read_address_1,
   input  logic [reg_addr_w-1:0] write_address,
   input  logic [word_w-1:0]     write_data,
   input  logic                  write_enable,
   output logic [word_w-1:0]     read_data_0,
   output logic [word_w-1:0]     read_data_1
);

   logic [word_w-1:0] regs [num_regs];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (write_enable) begin
         regs[write_address] <= write_data;
      end
   end

   // Write-through so a value written at the coming edge is already
   // visible to the instruction being decoded now
   always_comb begin
      if (read_address_0 == '0) begin
         read_data_0 = '0;
      end else if (write_enable && (write_address == read_address_0)) begin
         read_data_0 = write_data;
      end else begin
         read_data_0 = regs[read_address_0];
      end
   end

   always_comb begin
      if (read_address_1 == '0) begin
         read_data_1 = '0;
      end else if (write_enable && (write_address == read_address_1)) begin
         read_data_1 = write_data;
      end else begin
         read_data_1 = regs[read_address_1];
      end
   end

   // The decoder never lets a write to register 0 reach write-back
   a_no_write_reg0 : assert property (
      @(posedge clk) disable iff (!arst_n)
      write_enable |-> (write_address != '0)
   );

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage
   import isa_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [word_w-1:0]     instr,
   input  logic                  stall,
   input  logic                  squash,
   input  logic [word_w-1:0]     exe_result,
   input  logic                  wb_en,
   input  logic [reg_addr_w-1:0] wb_reg,
   input  logic [word_w-1:0]     wb_data,
   output logic [word_w-1:0]     exe_instr,
   output logic [word_w-1:0]     operand_0,
   output logic [word_w-1:0]     operand_1
);

   logic [reg_addr_w-1:0] rs0;
   logic [reg_addr_w-1:0] rs1;
   logic [word_w-1:0]     rf_data_0;
   logic [word_w-1:0]     rf_data_1;
   logic                  exe_writes;
   logic [reg_addr_w-1:0] exe_write_reg;
   logic [word_w-1:0]     operand_0_next;
   logic [word_w-1:0]     operand_1_next;
   logic [word_w-1:0]     instr_next;
   logic [word_w-1:0]     decode_instr_q;

   // Source registers of the incoming word
   instr_decoder u_decoder (
      .instr     (instr),
      .itype     (),
      .rd        (),
      .rs0       (rs0),
      .rs1       (rs1),
      .alu_op    (),
      .imm       (),
      .writes    (),
      .write_reg ()
   );

   // Destination of the word now in execute
   instr_decoder u_exe_decoder (
      .instr     (exe_instr),
      .itype     (),
      .rd        (),
      .rs0       (),
      .rs1       (),
      .alu_op    (),
      .imm       (),
      .writes    (exe_writes),
      .write_reg (exe_write_reg)
   );

   register_file u_register_file (
      .clk            (clk),
      .arst_n         (arst_n),
      .read_address_0 (rs0),
      .read_address_1 (rs1),
      .write_address  (wb_reg),
      .write_data     (wb_data),
      .write_enable   (wb_en),
      .read_data_0    (rf_data_0),
      .read_data_1    (rf_data_1)
   );

   // Execute result wins over the register file as the newer value
   assign operand_0_next = (exe_writes && (exe_write_reg == rs0)) ? exe_result : rf_data_0;
   assign operand_1_next = (exe_writes && (exe_write_reg == rs1)) ? exe_result : rf_data_1;

   // Stall or squash turns the incoming word into a no-op
   assign instr_next = (stall || squash) ? '0 : instr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         decode_instr_q <= '0;
         operand_0      <= '0;
         operand_1      <= '0;
      end else begin
         decode_instr_q <= instr_next;
         operand_0      <= operand_0_next;
         operand_1      <= operand_1_next;
      end
   end

   // Squash also kills the word already held for execute
   assign exe_instr = squash ? '0 : decode_instr_q;

   a_exe_instr_known : assert property (
      @(posedge clk) disable iff (!arst_n)
      !$isunknown(exe_instr)
   );

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage
   import isa_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [word_w-1:0]     exe_instr,
   input  logic [word_w-1:0]     operand_0,
   input  logic [word_w-1:0]     operand_1,
   output logic [word_w-1:0]     exe_result,
   output logic                  wb_en,
   output logic [reg_addr_w-1:0] wb_reg,
   output logic [word_w-1:0]     wb_data,
   output logic                  jump_taken,
   output logic [word_w-1:0]     jump_target
);

   logic [type_w-1:0]     itype;
   logic [alu_op_w-1:0]   alu_op;
   logic [word_w-1:0]     imm;
   logic                  writes;
   logic [reg_addr_w-1:0] write_reg;
   logic [word_w-1:0]     alu_result;
   logic                  take_jump;

   instr_decoder u_decoder (
      .instr     (exe_instr),
      .itype     (itype),
      .rd        (),
      .rs0       (),
      .rs1       (),
      .alu_op    (alu_op),
      .imm       (imm),
      .writes    (writes),
      .write_reg (write_reg)
   );

   always_comb begin
      case (alu_op)
         alu_add: alu_result = operand_0 + operand_1;
         alu_sub: alu_result = operand_0 - operand_1;
         alu_and: alu_result = operand_0 & operand_1;
         alu_or:  alu_result = operand_0 | operand_1;
         alu_xor: alu_result = operand_0 ^ operand_1;
         alu_shl: alu_result = operand_0 << operand_1[shamt_w-1:0];
         alu_shr: alu_result = operand_0 >> operand_1[shamt_w-1:0];
         default: alu_result = '0;
      endcase
   end

   // Also fed back to decode for forwarding
   always_comb begin
      case (itype)
         itype_alu:      exe_result = alu_result;
         itype_load_imm: exe_result = imm;
         default:        exe_result = '0;
      endcase
   end

   // Condition value nonzero means taken
   assign take_jump = (itype == itype_jump) && (operand_0 != '0);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_en       <= 1'b0;
         wb_reg      <= '0;
         wb_data     <= '0;
         jump_taken  <= 1'b0;
         jump_target <= '0;
      end else begin
         wb_en       <= writes;
         wb_reg      <= write_reg;
         wb_data     <= exe_result;
         jump_taken  <= take_jump;
         jump_target <= take_jump ? operand_1 : '0;
      end
   end

   a_wb_jump_exclusive : assert property (
      @(posedge clk) disable iff (!arst_n)
      !(wb_en && jump_taken)
   );

endmodule

/* source/pipeline_core.sv */
`timescale 1ns/1ns

module pipeline_core
   import isa_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [word_w-1:0]     instr,
   input  logic                  stall,
   input  logic                  squash,
   output logic                  wb_en,
   output logic [reg_addr_w-1:0] wb_reg,
   output logic [word_w-1:0]     wb_data,
   output logic                  jump_taken,
   output logic [word_w-1:0]     jump_target
);

   logic [word_w-1:0] exe_instr;
   logic [word_w-1:0] operand_0;
   logic [word_w-1:0] operand_1;
   logic [word_w-1:0] exe_result;

   decode_stage u_decode_stage (
      .clk        (clk),
      .arst_n     (arst_n),
      .instr      (instr),
      .stall      (stall),
      .squash     (squash),
      .exe_result (exe_result),
      .wb_en      (wb_en),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data),
      .exe_instr  (exe_instr),
      .operand_0  (operand_0),
      .operand_1  (operand_1)
   );

   // Write-back outputs double as the register file write port
   execute_stage u_execute_stage (
      .clk         (clk),
      .arst_n      (arst_n),
      .exe_instr   (exe_instr),
      .operand_0   (operand_0),
      .operand_1   (operand_1),
      .exe_result  (exe_result),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .jump_taken  (jump_taken),
      .jump_target (jump_target)
   );

endmodule

/* dv/pipeline_checker.sv */
`timescale 1ns/1ns

module pipeline_checker
   import isa_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [word_w-1:0]     instr,
   input  logic                  stall,
   input  logic                  squash,
   input  logic                  wb_en,
   input  logic [reg_addr_w-1:0] wb_reg,
   input  logic [word_w-1:0]     wb_data,
   input  logic                  jump_taken,
   input  logic [word_w-1:0]     jump_target,
   output int                    error_count,
   output int                    check_count
);

   logic [word_w-1:0]     model_regs [num_regs];
   logic [word_w-1:0]     accepted_q [$];
   logic [word_w-1:0]     exe_word;
   logic                  exp_wb_en;
   logic [reg_addr_w-1:0] exp_wb_reg;
   logic [word_w-1:0]     exp_wb_data;
   logic                  exp_jump_taken;
   logic [word_w-1:0]     exp_jump_target;
   int                    cycles_since_reset;

   // Architectural effect of one instruction on the model registers
   function automatic void reference_execute(
      input  logic [word_w-1:0]     word,
      output logic                  wr_en,
      output logic [reg_addr_w-1:0] wr_reg,
      output logic [word_w-1:0]     wr_data,
      output logic                  jmp,
      output logic [word_w-1:0]     target
   );
      instr_t            w;
      logic [word_w-1:0] a;
      logic [word_w-1:0] b;
      w       = word;
      a       = model_regs[w.reg_fmt.rs0];
      b       = model_regs[w.reg_fmt.rs1];
      wr_en   = 1'b0;
      wr_reg  = '0;
      wr_data = '0;
      jmp     = 1'b0;
      target  = '0;
      case (w.imm_fmt.itype)
         itype_load_imm: begin
            wr_reg  = w.imm_fmt.rd;
            wr_data = {{(word_w - imm_w){1'b0}}, w.imm_fmt.imm};
            wr_en   = (wr_reg != 0);
         end
         itype_alu: begin
            wr_reg = w.reg_fmt.rd;
            wr_en  = (wr_reg != 0);
            case (w.reg_fmt.op)
               alu_add: wr_data = a + b;
               alu_sub: wr_data = a - b;
               alu_and: wr_data = a & b;
               alu_or:  wr_data = a | b;
               alu_xor: wr_data = a ^ b;
               alu_shl: wr_data = a << b[4:0];
               alu_shr: wr_data = a >> b[4:0];
               default: wr_data = '0;
            endcase
         end
         itype_jump: begin
            jmp    = (a != 0);
            target = jmp ? b : '0;
         end
         default: begin
            wr_en = 1'b0;
         end
      endcase
   endfunction

   task automatic compare_value(input string name, input logic [word_w-1:0] expected,
                                input logic [word_w-1:0] actual);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL %s: expected 0x%08h, actual 0x%08h at %0t", name, expected, actual,
                  $time);
      end
   endtask

   initial begin
      error_count = 0;
      check_count = 0;
   end

   // Model pipeline advances on the same edge as the DUT
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
         end
         accepted_q.delete();
         accepted_q.push_back('0);
         exp_wb_en          = 1'b0;
         exp_wb_reg         = '0;
         exp_wb_data        = '0;
         exp_jump_taken     = 1'b0;
         exp_jump_target    = '0;
         cycles_since_reset = 0;
      end else begin
         // Word held in decode reaches execute unless squashed
         exe_word = accepted_q.pop_front();
         if (squash) begin
            exe_word = '0;
         end
         reference_execute(exe_word, exp_wb_en, exp_wb_reg, exp_wb_data, exp_jump_taken,
                           exp_jump_target);
         if (exp_wb_en) begin
            model_regs[exp_wb_reg] = exp_wb_data;
         end
         accepted_q.push_back((stall || squash) ? '0 : instr);
         if (cycles_since_reset < 2) begin
            cycles_since_reset++;
         end
      end
   end

   // Registered outputs are settled by the falling edge
   always @(negedge clk) begin
      if (arst_n && (cycles_since_reset >= 2)) begin
         check_count++;
         compare_value("wb_en", word_w'(exp_wb_en), word_w'(wb_en));
         compare_value("jump_taken", word_w'(exp_jump_taken), word_w'(jump_taken));
         compare_value("jump_target", exp_jump_target, jump_target);
         // Write port address and data only matter while enabled
         if (exp_wb_en) begin
            compare_value("wb_reg", word_w'(exp_wb_reg), word_w'(wb_reg));
            compare_value("wb_data", exp_wb_data, wb_data);
         end
      end
   end

endmodule

/* dv/tb_pipeline_core.sv */
`timescale 1ns/1ns

module tb_pipeline_core
   import isa_pkg::*;
();

   // Instructions issued per test are 18 + 28 + 8 + 7 + 8 + 300
   localparam int test_instrs    = 369;
   localparam int num_tests      = 6;
   localparam int timeout_cycles = test_instrs + 20 * num_tests;

   logic                  clk;
   logic                  arst_n;
   logic [word_w-1:0]     instr;
   logic                  stall;
   logic                  squash;
   logic                  wb_en;
   logic [reg_addr_w-1:0] wb_reg;
   logic [word_w-1:0]     wb_data;
   logic                  jump_taken;
   logic [word_w-1:0]     jump_target;
   int                    error_count;
   int                    check_count;
   int                    errors_at_start;
   int                    direct_errors;
   int                    tests_passed;
   int                    tests_failed;
   int                    cycle_count;

   pipeline_core uut (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr       (instr),
      .stall       (stall),
      .squash      (squash),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .jump_taken  (jump_taken),
      .jump_target (jump_target)
   );

   pipeline_checker u_checker (
      .clk         (clk),
      .arst_n      (arst_n),
      .instr       (instr),
      .stall       (stall),
      .squash      (squash),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .jump_taken  (jump_taken),
      .jump_target (jump_target),
      .error_count (error_count),
      .check_count (check_count)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [word_w-1:0] load_imm_word(input logic [4:0] rd,
                                                       input logic [21:0] imm);
      return {itype_load_imm, rd, imm};
   endfunction

   function automatic logic [word_w-1:0] alu_word(input logic [4:0] op, input logic [4:0] rd,
                                                  input logic [4:0] rs0, input logic [4:0] rs1);
      return {itype_alu, rd, rs0, rs1, op, 7'd0};
   endfunction

   function automatic logic [word_w-1:0] jump_word(input logic [4:0] rs0, input logic [4:0] rs1);
      return {itype_jump, 5'd0, rs0, rs1, 5'd0, 7'd0};
   endfunction

   // Small register range so dependencies show up often
   function automatic logic [word_w-1:0] random_word();
      int unsigned kind;
      kind = $urandom_range(9, 0);
      if (kind == 0) begin
         return '0;
      end else if (kind <= 3) begin
         return load_imm_word(5'($urandom_range(7, 0)), 22'($urandom));
      end else if (kind <= 6) begin
         return alu_word(5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)),
                         5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)));
      end else if (kind <= 8) begin
         return jump_word(5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)));
      end else begin
         return $urandom;
      end
   endfunction

   task automatic drive_cycle(input logic [word_w-1:0] word, input logic stall_in,
                              input logic squash_in);
      @(posedge clk);
      #5;
      instr  = word;
      stall  = stall_in;
      squash = squash_in;
   endtask

   task automatic issue(input logic [word_w-1:0] word);
      drive_cycle(word, 1'b0, 1'b0);
   endtask

   // Every output register comes out of reset as zero
   task automatic check_cleared(input string name, input logic [word_w-1:0] actual);
      if (actual !== '0) begin
         $display("FAIL %s after reset: expected 0x00000000, actual 0x%08h", name, actual);
         direct_errors++;
      end
   endtask

   task automatic begin_test();
      errors_at_start = error_count;
      direct_errors   = 0;
   endtask

   // Drain lets the last instruction reach the outputs and get checked
   task automatic end_test(input string name);
      int errors;
      repeat (3) issue('0);
      errors = error_count - errors_at_start + direct_errors;
      if (errors == 0) begin
         tests_passed++;
         $display("Test %0d %s passed", tests_passed + tests_failed, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s failed with %0d errors", tests_passed + tests_failed, name,
                  errors);
      end
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < timeout_cycles) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Run timed out after %0d cycles", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      logic [word_w-1:0] word;
      logic [4:0]        op;
      void'($urandom(5));
      arst_n       = 1'b0;
      instr        = '0;
      stall        = 1'b0;
      squash       = 1'b0;
      tests_passed = 0;
      tests_failed = 0;
      repeat (4) @(posedge clk);
      #5;
      arst_n = 1'b1;

      begin_test();
      check_cleared("wb_en", word_w'(wb_en));
      check_cleared("wb_reg", word_w'(wb_reg));
      check_cleared("wb_data", wb_data);
      check_cleared("jump_taken", word_w'(jump_taken));
      check_cleared("jump_target", jump_target);
      for (int i = 1; i <= 6; i++) begin
         issue(load_imm_word(5'(i), 22'(i * 32'h0004_1357)));
      end
      issue(load_imm_word(5'd7, 22'h3f_ffff));
      issue(load_imm_word(5'd0, 22'h00_1234));
      repeat (3) issue('0);
      // Copy each register out through the write port
      for (int i = 1; i <= 7; i++) begin
         issue(alu_word(alu_add, 5'(8 + i), 5'(i), 5'd0));
      end
      end_test("reset_load_imm");

      begin_test();
      issue(load_imm_word(5'd3, 22'h00_0013));
      for (int i = 0; i < 9; i++) begin
         op = (i < 8) ? 5'(i) : 5'd31;
         issue(load_imm_word(5'd1, 22'(32'h2a5a5 + i * 32'h1111)));
         issue(alu_word(op, 5'd2, 5'd1, 5'd3));
         issue(alu_word(op, 5'd4, 5'd2, 5'd1));
      end
      end_test("alu_forwarding");

      begin_test();
      issue(load_imm_word(5'd5, 22'h0));
      issue(load_imm_word(5'd6, 22'h1));
      issue(load_imm_word(5'd7, 22'h3a_bcde));
      issue(jump_word(5'd6, 5'd7));
      issue(jump_word(5'd5, 5'd7));
      issue(jump_word(5'd0, 5'd7));
      issue(load_imm_word(5'd8, 22'h111));
      issue(jump_word(5'd8, 5'd8));
      end_test("jumps");

      begin_test();
      issue(load_imm_word(5'd1, 22'h55));
      word = alu_word(alu_add, 5'd2, 5'd1, 5'd1);
      drive_cycle(word, 1'b1, 1'b0);
      drive_cycle(word, 1'b1, 1'b0);
      issue(word);
      issue(load_imm_word(5'd3, 22'h7));
      word = alu_word(alu_sub, 5'd4, 5'd3, 5'd2);
      drive_cycle(word, 1'b1, 1'b0);
      issue(word);
      end_test("stall");

      begin_test();
      issue(load_imm_word(5'd20, 22'haaa));
      issue(load_imm_word(5'd21, 22'hbbb));
      drive_cycle(load_imm_word(5'd22, 22'hccc), 1'b0, 1'b1);
      issue(alu_word(alu_add, 5'd23, 5'd20, 5'd21));
      issue(load_imm_word(5'd24, 22'h1));
      issue(jump_word(5'd24, 5'd24));
      drive_cycle(load_imm_word(5'd25, 22'hddd), 1'b0, 1'b1);
      issue(alu_word(alu_add, 5'd26, 5'd24, 5'd25));
      end_test("squash");

      begin_test();
      for (int i = 0; i < 300; i++) begin
         word = random_word();
         // A stalled word is held and presented again
         if ($urandom_range(7, 0) == 0) begin
            drive_cycle(word, 1'b1, 1'b0);
         end
         drive_cycle(word, 1'b0, ($urandom_range(9, 0) == 0));
      end
      end_test("random_mix");

      $display("Tests passed %0d, failed %0d, checks %0d, mismatches %0d", tests_passed,
               tests_failed, check_count, error_count);
      if (tests_failed == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* files.f */
source/isa_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline_core.sv
dv/pipeline_checker.sv
dv/tb_pipeline_core.sv

/* Bender.yml */
package:
  name: pipeline_core

sources:
  - source/isa_pkg.sv
  - source/instr_decoder.sv
  - source/register_file.sv
  - source/decode_stage.sv
  - source/execute_stage.sv
  - source/pipeline_core.sv
  - target: test
    files:
      - dv/pipeline_checker.sv
      - dv/tb_pipeline_core.sv
